//--- source/rename_defines.svh
// Rename stage sizing macros
// Physical register count, banking, architectural register count,
// the first index the free rings hand out and the map initialization length

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Total physical registers across all banks
`define RN_PREGS 256

// Number of physical register banks, selected by the top tag bits
`define RN_BANKS 4

// Indices per bank
`define RN_BANK_DEPTH 64

// Architectural registers visible to the instruction set
`define RN_AREGS 32

// Indices below this are held by the reset mapping in every bank
`define RN_RING_BASE 8

// Cycles spent writing the reset mapping, one register per cycle
`define RN_INIT_LEN 32

`endif

//--- source/rename_pkg.sv
// Rename stage types
// Register tag types, opcode and control state enums,
// and the request and response structs of the rename interface

`include "rename_defines.svh"

package rename_pkg;

	// ========================================================================
	// Register tags
	// ========================================================================

	localparam int PREG_W = $clog2(`RN_PREGS);
	localparam int BANK_W = $clog2(`RN_BANKS);
	localparam int IDX_W  = $clog2(`RN_BANK_DEPTH);
	localparam int AREG_W = $clog2(`RN_AREGS);

	// Physical tag, bank number in the top bits and bank index below it
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [BANK_W-1:0] bank_t;
	typedef logic [IDX_W-1:0]  idx_t;
	typedef logic [AREG_W-1:0] areg_t;

	// ========================================================================
	// Opcodes and states
	// ========================================================================

	// ALU has a destination and two sources, STORE only reads two sources
	typedef enum logic [1:0] {
		RN_NOP   = 2'd0,
		RN_ALU   = 2'd1,
		RN_STORE = 2'd2
	} rn_op_e;

	typedef enum logic {
		ST_INIT = 1'b0,
		ST_RUN  = 1'b1
	} rn_state_e;

	typedef struct packed {
		rn_op_e op;
		areg_t  dest;
		areg_t  src1;
		areg_t  src2;
	} rename_req_t;

	// The old mapping in pold goes on to retirement for later freeing
	typedef struct packed {
		logic   valid;
		rn_op_e op;
		preg_t  pdest;
		preg_t  psrc1;
		preg_t  psrc2;
		preg_t  pold;
	} rename_rsp_t;

endpackage

//--- source/preg_bank_ring.sv
// Free index ring of one physical register bank
// Rotates through indices RN_RING_BASE up to the top of the bank
// and presents the bank-tagged head register

`timescale 1ns/1ps
`include "rename_defines.svh"

module preg_bank_ring #(
	parameter int BANK = 0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              rot,
	output rename_pkg::preg_t head
);

	localparam int RING_LEN = `RN_BANK_DEPTH - `RN_RING_BASE;
	localparam int IDX_W    = rename_pkg::IDX_W;

	// Ring storage, entry 0 is the front and matches head_idx
	rename_pkg::idx_t ring [RING_LEN];
	rename_pkg::idx_t head_idx;

	// The ring is loaded in ascending order so reuse follows strict round robin
	// Each rotation moves the front entry to the back of the ring
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RING_LEN; i++) begin
				ring[i] <= rename_pkg::idx_t'(`RN_RING_BASE + i);
			end
			head_idx <= rename_pkg::idx_t'(`RN_RING_BASE);
		end else if (rot) begin
			for (int i = 0; i < RING_LEN - 1; i++) begin
				ring[i] <= ring[i+1];
			end
			ring[RING_LEN-1] <= ring[0];
			// Next front entry becomes the new head
			head_idx <= ring[1];
		end
	end

	assign head = {rename_pkg::bank_t'(BANK), head_idx};

	// Indices below the base belong to the reset mapping and must never be handed out
	a_head_above_base: assert property (@(posedge clk) disable iff (rst)
		head[IDX_W-1:0] >= `RN_RING_BASE);

	// A rotation steps the head to the next index and wraps back to the base
	a_head_order: assert property (@(posedge clk) disable iff (rst)
		rot |=> (head[IDX_W-1:0] == (($past(head[IDX_W-1:0]) == `RN_BANK_DEPTH - 1) ?
			rename_pkg::idx_t'(`RN_RING_BASE) : $past(head[IDX_W-1:0]) + 1'b1)));

endmodule

//--- source/rename_map_table.sv
// Architectural to physical register map
// Three combinational read ports for the sources and the old destination,
// one clocked write port shared by initialization and allocation

`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_map_table (
	input  logic              clk,
	input  logic              rst,
	input  rename_pkg::areg_t rd_a,
	input  rename_pkg::areg_t rd_b,
	input  rename_pkg::areg_t rd_c,
	output rename_pkg::preg_t rd_a_tag,
	output rename_pkg::preg_t rd_b_tag,
	output rename_pkg::preg_t rd_c_tag,
	input  logic              we,
	input  rename_pkg::areg_t wa,
	input  rename_pkg::preg_t wd
);

	// ========================================================================
	// Storage
	// ========================================================================

	// One physical tag per architectural register
	rename_pkg::preg_t map [`RN_AREGS];

	// A write lands at the clock edge, so a read in the same cycle returns
	// the previous mapping and a read in the next cycle the new one
	always_ff @(posedge clk) begin
		if (we) begin
			map[wa] <= wd;
		end
	end

	// ========================================================================
	// Read ports
	// ========================================================================

	// Port a serves src1, port b serves src2
	assign rd_a_tag = map[rd_a];
	assign rd_b_tag = map[rd_b];

	// Port c returns the mapping that the destination is about to replace
	assign rd_c_tag = map[rd_c];

	// Write addresses come from the control, either the init counter or the request
	a_wa_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(wa));

endmodule

//--- source/rename_ctrl.sv
// Rename control
// Init and run FSM that fills the map with the reset mapping,
// round robin destination bank pointer, head selection, map write steering
// and the registered rename response

`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_ctrl (
	input  logic                              clk,
	input  logic                              rst,
	input  rename_pkg::rename_req_t           req,
	output logic                              ready,
	output rename_pkg::rename_rsp_t           rsp,
	output logic [`RN_BANKS-1:0]              rot,
	input  rename_pkg::preg_t [`RN_BANKS-1:0] heads,
	output rename_pkg::areg_t                 rd_a,
	output rename_pkg::areg_t                 rd_b,
	output rename_pkg::areg_t                 rd_c,
	input  rename_pkg::preg_t                 rd_a_tag,
	input  rename_pkg::preg_t                 rd_b_tag,
	input  rename_pkg::preg_t                 rd_c_tag,
	output logic                              we,
	output rename_pkg::areg_t                 wa,
	output rename_pkg::preg_t                 wd
);

	localparam int CNT_W = $clog2(`RN_INIT_LEN);

	rename_pkg::rn_state_e state;
	logic [CNT_W-1:0]      init_cnt;
	rename_pkg::bank_t     bank_ptr;
	logic                  accept;
	logic                  alloc;
	rename_pkg::preg_t     init_tag;
	rename_pkg::preg_t     new_tag;
	logic                  rsp_valid;
	rename_pkg::rn_op_e    rsp_op;
	rename_pkg::preg_t     rsp_pdest;
	rename_pkg::preg_t     rsp_psrc1;
	rename_pkg::preg_t     rsp_psrc2;
	rename_pkg::preg_t     rsp_pold;

	// ========================================================================
	// Initialization FSM
	// ========================================================================

	// One architectural register is written per cycle, then the unit goes live
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= rename_pkg::ST_INIT;
			init_cnt <= '0;
		end else if (state == rename_pkg::ST_INIT) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == CNT_W'(`RN_INIT_LEN - 1)) begin
				state <= rename_pkg::ST_RUN;
			end
		end
	end

	assign ready = (state == rename_pkg::ST_RUN);

	// Register i sits in bank i mod 4 at index i div 4
	assign init_tag = {rename_pkg::bank_t'(init_cnt % `RN_BANKS),
		rename_pkg::idx_t'(init_cnt / `RN_BANKS)};

	// ========================================================================
	// Allocation
	// ========================================================================

	assign accept  = ready && (req.op != rename_pkg::RN_NOP);
	assign alloc   = ready && (req.op == rename_pkg::RN_ALU);
	assign new_tag = heads[bank_ptr];

	// Destination banks are taken in turn, one step per allocation
	always_ff @(posedge clk) begin
		if (rst) begin
			bank_ptr <= '0;
		end else if (alloc) begin
			bank_ptr <= bank_ptr + 1'b1;
		end
	end

	// Only the bank that just gave up its head rotates
	always_comb begin
		rot = '0;
		if (alloc) begin
			rot[bank_ptr] = 1'b1;
		end
	end

	// Sources and the old destination mapping are read in the acceptance cycle
	assign rd_a = req.src1;
	assign rd_b = req.src2;
	assign rd_c = req.dest;

	// Write port belongs to the init walk first, then to allocations
	assign we = (state == rename_pkg::ST_INIT) || alloc;
	assign wa = (state == rename_pkg::ST_INIT) ? rename_pkg::areg_t'(init_cnt) : req.dest;
	assign wd = (state == rename_pkg::ST_INIT) ? init_tag : new_tag;

	// ========================================================================
	// Response register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= accept;
		end
	end

	// Stores carry no destination, so pdest and pold read as zero for them
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_op    <= req.op;
			rsp_psrc1 <= rd_a_tag;
			rsp_psrc2 <= rd_b_tag;
			rsp_pdest <= alloc ? new_tag : '0;
			rsp_pold  <= alloc ? rd_c_tag : '0;
		end
	end

	assign rsp = '{valid: rsp_valid, op: rsp_op, pdest: rsp_pdest,
		psrc1: rsp_psrc1, psrc2: rsp_psrc2, pold: rsp_pold};

	a_rot_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rot));

	// Rings must stay at their reset heads while the map is being filled
	a_rot_run_only: assert property (@(posedge clk) disable iff (rst)
		(state != rename_pkg::ST_RUN) |-> (rot == '0));

	a_rsp_after_ready: assert property (@(posedge clk) disable iff (rst)
		rsp.valid |-> $past(ready));

endmodule

//--- source/rename_unit.sv
// Rename unit top level
// Connects the control, the four free index rings and the map table

`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  rename_pkg::rename_req_t req,
	output logic                    ready,
	output rename_pkg::rename_rsp_t rsp
);

	// Rotate pulses and head tags, one per bank
	logic [`RN_BANKS-1:0]              rot;
	rename_pkg::preg_t [`RN_BANKS-1:0] heads;

	// Map table ports
	rename_pkg::areg_t rd_a;
	rename_pkg::areg_t rd_b;
	rename_pkg::areg_t rd_c;
	rename_pkg::preg_t rd_a_tag;
	rename_pkg::preg_t rd_b_tag;
	rename_pkg::preg_t rd_c_tag;
	logic              we;
	rename_pkg::areg_t wa;
	rename_pkg::preg_t wd;

	rename_ctrl u_rename_ctrl (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.ready    (ready),
		.rsp      (rsp),
		.rot      (rot),
		.heads    (heads),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.rd_c     (rd_c),
		.rd_a_tag (rd_a_tag),
		.rd_b_tag (rd_b_tag),
		.rd_c_tag (rd_c_tag),
		.we       (we),
		.wa       (wa),
		.wd       (wd)
	);

	// Bank number is baked into each ring's head tag
	for (genvar b = 0; b < `RN_BANKS; b++) begin : g_bank
		preg_bank_ring #(
			.BANK (b)
		) u_ring (
			.clk  (clk),
			.rst  (rst),
			.rot  (rot[b]),
			.head (heads[b])
		);
	end

	rename_map_table u_rename_map_table (
		.clk      (clk),
		.rst      (rst),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.rd_c     (rd_c),
		.rd_a_tag (rd_a_tag),
		.rd_b_tag (rd_b_tag),
		.rd_c_tag (rd_c_tag),
		.we       (we),
		.wa       (wa),
		.wd       (wd)
	);

endmodule

//--- tb/tb_rename_unit.sv
// Directed testbench for the rename unit
// Reference model of the map table, the bank pointer and the per-bank
// allocation counts, an LCG for random operands, a watchdog and one task per test

`timescale 1ns/1ps
`include "rename_defines.svh"

module tb_rename_unit;

	localparam int RING_LEN      = `RN_BANK_DEPTH - `RN_RING_BASE;
	localparam int DIRECTED_REQS = 80;
	localparam int RAND_REQS     = 400;
	localparam int TIMEOUT_NS    = (DIRECTED_REQS + RAND_REQS) * 10
		+ (10 + `RN_INIT_LEN) * 10 + 2000;

	logic                    clk;
	logic                    rst;
	rename_pkg::rename_req_t req;
	logic                    ready;
	rename_pkg::rename_rsp_t rsp;

	// Model of the map, the bank pointer and how often each bank has allocated
	rename_pkg::preg_t       model_map [`RN_AREGS];
	int                      model_bank;
	int                      alloc_cnt [`RN_BANKS];
	// Response due one cycle after the request currently on the bus
	rename_pkg::rename_rsp_t pending;
	logic [31:0]             seed;
	int                      errors;
	int                      checks;

	rename_unit u_rename_unit (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.ready (ready),
		.rsp   (rsp)
	);

	always #5 clk = ~clk;

	// ========================================================================
	// Helpers and reference model
	// ========================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Bank in the top tag bits, index in the low bits
	function automatic rename_pkg::preg_t make_tag(input int bank, input int idx);
		return rename_pkg::preg_t'(bank * `RN_BANK_DEPTH + idx);
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// Sources and the old mapping are read before the destination is remapped
	task automatic predict_rsp(input rename_pkg::rename_req_t r,
		output rename_pkg::rename_rsp_t e);
		int b;
		e = '0;
		e.valid = (r.op != rename_pkg::RN_NOP);
		e.op    = r.op;
		e.psrc1 = model_map[r.src1];
		e.psrc2 = model_map[r.src2];
		if (r.op == rename_pkg::RN_ALU) begin
			b = model_bank;
			// The k-th allocation of a bank hands out index base + k mod ring length
			e.pdest = make_tag(b, `RN_RING_BASE + alloc_cnt[b] % RING_LEN);
			e.pold  = model_map[r.dest];
			model_map[r.dest] = e.pdest;
			alloc_cnt[b]++;
			model_bank = (model_bank + 1) % `RN_BANKS;
		end
	endtask

	task automatic check_rsp(input rename_pkg::rename_rsp_t e);
		compare_field("rsp.valid", 32'(rsp.valid), 32'(e.valid));
		if (e.valid) begin
			compare_field("rsp.op", 32'(rsp.op), 32'(e.op));
			compare_field("rsp.psrc1", 32'(rsp.psrc1), 32'(e.psrc1));
			compare_field("rsp.psrc2", 32'(rsp.psrc2), 32'(e.psrc2));
			// Stores carry no destination
			if (e.op == rename_pkg::RN_ALU) begin
				compare_field("rsp.pdest", 32'(rsp.pdest), 32'(e.pdest));
				compare_field("rsp.pold", 32'(rsp.pold), 32'(e.pold));
			end
		end
	endtask

	// Drive one request at the rising edge, then check the previous one's response
	// at the falling edge, which is exactly one cycle after its acceptance
	task automatic send_req(input rename_pkg::rn_op_e op, input int dest,
		input int src1, input int src2);
		rename_pkg::rename_req_t r;
		rename_pkg::rename_rsp_t e;
		r.op   = op;
		r.dest = rename_pkg::areg_t'(dest);
		r.src1 = rename_pkg::areg_t'(src1);
		r.src2 = rename_pkg::areg_t'(src2);
		@(posedge clk);
		req <= r;
		predict_rsp(r, e);
		@(negedge clk);
		check_rsp(pending);
		pending = e;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	// Ready stays low while the map is filled, one register per cycle
	task automatic test_init_ready();
		int low;
		low = 0;
		@(negedge clk);
		while (!ready && low < 2 * `RN_INIT_LEN) begin
			compare_field("rsp.valid", 32'(rsp.valid), 32'd0);
			low++;
			@(negedge clk);
		end
		assert (ready) else begin
			errors++;
			$display("ready never rose after reset was released");
		end
		compare_field("ready low cycle count", 32'(low), 32'(`RN_INIT_LEN));
	endtask

	task automatic test_store_reset_map();
		for (int r = 0; r < `RN_AREGS; r++) begin
			send_req(rename_pkg::RN_STORE, 0, r, r);
		end
	endtask

	task automatic test_alu_sequence();
		for (int i = 0; i < 16; i++) begin
			send_req(rename_pkg::RN_ALU, (i * 3) % `RN_AREGS, i, `RN_AREGS - 1 - i);
		end
	endtask

	// A reader right behind the writer sees the new tag, a self source the old one
	task automatic test_back_to_back();
		send_req(rename_pkg::RN_ALU, 7, 1, 2);
		send_req(rename_pkg::RN_STORE, 0, 7, 7);
		send_req(rename_pkg::RN_ALU, 9, 9, 9);
		send_req(rename_pkg::RN_ALU, 10, 9, 10);
		send_req(rename_pkg::RN_STORE, 0, 10, 9);
		send_req(rename_pkg::RN_ALU, 7, 7, 10);
	endtask

	// Idle cycles allocate nothing and leave every mapping as it was
	task automatic test_nop();
		for (int i = 0; i < 3; i++) begin
			send_req(rename_pkg::RN_NOP, i, i, i);
		end
		send_req(rename_pkg::RN_ALU, 3, 4, 5);
		for (int i = 0; i < `RN_AREGS / 2; i++) begin
			send_req(rename_pkg::RN_STORE, 0, 2 * i, 2 * i + 1);
		end
	endtask

	// Enough allocations that every ring wraps past its top index
	task automatic test_random();
		rename_pkg::rn_op_e op;
		for (int i = 0; i < RAND_REQS; i++) begin
			seed = lcg_next(seed);
			op = (seed[31:29] == 3'd0) ? rename_pkg::RN_STORE : rename_pkg::RN_ALU;
			send_req(op, int'(seed[28:24]), int'(seed[23:19]), int'(seed[18:14]));
		end
		for (int b = 0; b < `RN_BANKS; b++) begin
			assert (alloc_cnt[b] > RING_LEN) else begin
				errors++;
				$display("bank %0d ring did not wrap, only %0d allocations", b, alloc_cnt[b]);
			end
		end
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		req        = '0;
		pending    = '0;
		seed       = 32'hcaf8_6094;
		errors     = 0;
		checks     = 0;
		model_bank = 0;
		// Register r starts in bank r mod 4 at index r div 4
		for (int r = 0; r < `RN_AREGS; r++) begin
			model_map[r] = make_tag(r % `RN_BANKS, r / `RN_BANKS);
		end
		for (int b = 0; b < `RN_BANKS; b++) begin
			alloc_cnt[b] = 0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		test_init_ready();
		test_store_reset_map();
		test_alu_sequence();
		test_back_to_back();
		test_nop();
		test_random();
		// One idle cycle collects the last response
		send_req(rename_pkg::RN_NOP, 0, 0, 0);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- rename_unit.f
+incdir+source
source/rename_pkg.sv
source/preg_bank_ring.sv
source/rename_map_table.sv
source/rename_ctrl.sv
source/rename_unit.sv
tb/tb_rename_unit.sv

//--- Makefile
# Verilator build and run of the rename unit testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= rename_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
